/* build.f */
stepper_pkg.sv
spi_slave.sv
spi_word_packer.sv
command_decoder.sv
stepper_axis.sv
reply_arbiter.sv
stepper_top.sv
tb_stepper_top.sv

/* command_decoder.sv */
`timescale 1ns/1ps

module command_decoder import stepper_pkg::*; #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic                    word_received,
  input  logic                    rst_n,
  input  logic                    word_valid,
  input  word_t                   word_data,
  output logic                    move_push0,
  output logic                    move_push1,
  output logic [step_count_w-1:0] move_steps,
  input  logic                    credit_return0,
  input  logic                    credit_return1,
  input  logic [7:0]              queue_level0,
  input  logic [7:0]              queue_level1,
  output logic [7:0]              pwm_duty_a,
  output logic [7:0]              pwm_duty_b,
  output logic                    reply_req,
  input  logic                    reply_grant,
  output word_t                   reply_data
);

  localparam int CW = $clog2(MOVE_DEPTH + 1);

  command_word_u cmd;
  logic [CW-1:0] credit0;
  logic [CW-1:0] credit1;
  logic [7:0]    drop_count;

  logic is_move0;
  logic is_move1;
  logic take0;
  logic take1;
  logic drop;

  assign cmd = word_data;

  assign is_move0 = word_valid && (cmd.move.opcode == op_move0);
  assign is_move1 = word_valid && (cmd.move.opcode == op_move1);

  // A move goes out only against a credit
  assign take0 = is_move0 && (credit0 != '0);
  assign take1 = is_move1 && (credit1 != '0);
  assign drop  = (is_move0 && credit0 == '0) || (is_move1 && credit1 == '0);

  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      move_push0 <= 1'b0;
      move_push1 <= 1'b0;
      credit0    <= CW'(MOVE_DEPTH);
      credit1    <= CW'(MOVE_DEPTH);
      drop_count <= 8'd0;
      pwm_duty_a <= 8'd0;
      pwm_duty_b <= 8'd0;
      reply_req  <= 1'b0;
    end else begin
      move_push0 <= take0;
      move_push1 <= take1;
      credit0    <= credit0 + CW'(credit_return0) - CW'(take0);
      credit1    <= credit1 + CW'(credit_return1) - CW'(take1);

      if (drop)
        drop_count <= drop_count + 8'd1;

      if (word_valid && cmd.cfg.opcode == op_pwm) begin
        pwm_duty_a <= cmd.cfg.duty_a;
        pwm_duty_b <= cmd.cfg.duty_b;
      end

      // Every word answers, a new word simply refreshes a pending reply
      if (word_valid)
        reply_req <= 1'b1;
      else if (reply_grant)
        reply_req <= 1'b0;
    end
  end

  always_ff @(posedge word_received) begin
    if (take0 || take1)
      move_steps <= cmd.move.steps;
    if (word_valid) begin
      if (cmd.move.opcode == op_status)
        reply_data <= {reply_status_tag, drop_count, queue_level1, queue_level0};
      else
        reply_data <= word_data; // Echo
    end
  end

endmodule

/* reply_arbiter.sv */
`timescale 1ns/1ps

module reply_arbiter import stepper_pkg::*; (
  input  logic       word_received,
  input  logic       rst_n,
  input  logic [2:0] req,
  input  word_t      req_data0,
  input  word_t      req_data1,
  input  word_t      req_data2,
  output logic [2:0] grant,
  output word_t      reply_word
);

  logic [1:0] last;     // Index of the last winner
  logic [2:0] elig;
  logic [2:0] pick;
  logic [1:0] pick_idx;

  always_comb begin
    int idx;
    // A requester sees its grant one clock late, so mask it meanwhile
    elig     = req & ~grant;
    pick     = 3'b000;
    pick_idx = last;
    for (int i = 1; i <= 3; i++) begin
      idx = (int'(last) + i) % 3;
      if (pick == 3'b000 && elig[idx]) begin
        pick[idx] = 1'b1;
        pick_idx  = 2'(idx);
      end
    end
  end

  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      last       <= 2'd2; // Requester 0 goes first
      grant      <= 3'b000;
      reply_word <= '0;
    end else begin
      grant <= pick;
      if (pick != 3'b000)
        last <= pick_idx;

      // Load the word of whoever holds the grant now
      if (grant[0])      reply_word <= req_data0;
      else if (grant[1]) reply_word <= req_data1;
      else if (grant[2]) reply_word <= req_data2;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds tb_stepper_top with Verilator, runs it, and judges the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_stepper_top \
  -f build.f -o sim_stepper > sim.log 2>&1 &&
  ./obj_dir/sim_stepper >> sim.log 2>&1

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
echo "Run passed"
exit 0

/* spi_slave.sv */
`timescale 1ns/1ps

module spi_slave (
  input  logic       word_received,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       ssel,
  input  logic       mosi,
  output logic       miso,
  input  logic [7:0] tx_byte,
  output logic       byte_valid,
  output logic [7:0] byte_data
);

  logic [2:0] sck_s;  // Two sync stages plus one for edge detect
  logic [1:0] mosi_s;
  logic [2:0] ssel_s; // One stage behind the packer's copy
  logic [2:0] bit_cnt;
  logic [7:0] rx_sh;
  logic [7:0] tx_sh;

  logic sck_rise;
  logic sck_fall;
  logic active;

  assign sck_rise = sck_s[1] & ~sck_s[2];
  assign sck_fall = ~sck_s[1] & sck_s[2];
  assign active   = ~ssel_s[2];

  assign miso      = tx_sh[7]; // MSB first
  assign byte_data = rx_sh;

  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      sck_s      <= 3'b000;
      mosi_s     <= 2'b00;
      ssel_s     <= 3'b111;
      bit_cnt    <= 3'd0;
      rx_sh      <= 8'h00;
      tx_sh      <= 8'h00;
      byte_valid <= 1'b0;
    end else begin
      sck_s      <= {sck_s[1:0], sck};
      mosi_s     <= {mosi_s[0], mosi};
      ssel_s     <= {ssel_s[1:0], ssel};
      byte_valid <= 1'b0;

      if (!active) begin
        // Deselected, so framing restarts and the first reply byte waits in place
        bit_cnt <= 3'd0;
        tx_sh   <= tx_byte;
      end else begin
        if (sck_rise) begin
          rx_sh   <= {rx_sh[6:0], mosi_s[1]};
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            byte_valid <= 1'b1;
        end

        // Fall after a byte's last bit brings in the next reply byte
        if (sck_fall) begin
          if (bit_cnt == 3'd0)
            tx_sh <= tx_byte;
          else
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
      end
    end
  end

endmodule

/* spi_word_packer.sv */
`timescale 1ns/1ps

module spi_word_packer import stepper_pkg::*; (
  input  logic       word_received,
  input  logic       rst_n,
  input  logic       ssel,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic [7:0] tx_byte,
  input  word_t      reply_word,
  output logic       word_valid,
  output word_t      word_data
);

  logic [1:0]  ssel_q;
  logic [1:0]  byte_cnt;
  logic [23:0] acc;      // Bytes 0..2 of the word in progress
  word_t       snap;     // Reply frozen for the whole word

  logic idle;

  assign idle = ssel_q[1];

  // Lowest byte goes out first
  assign tx_byte = snap[{byte_cnt, 3'b000} +: 8];

  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      ssel_q     <= 2'b11;
      byte_cnt   <= 2'd0;
      word_valid <= 1'b0;
      snap       <= '0;
    end else begin
      ssel_q     <= {ssel_q[0], ssel};
      word_valid <= 1'b0;

      if (idle) begin
        byte_cnt <= 2'd0; // Partial word is thrown away
        snap     <= reply_word;
      end else if (byte_valid) begin
        byte_cnt <= byte_cnt + 2'd1;
        if (byte_cnt == 2'd3) begin
          word_valid <= 1'b1;
          snap       <= reply_word; // Next word inside the same frame
        end
      end
    end
  end

  always_ff @(posedge word_received) begin
    if (!idle && byte_valid) begin
      if (byte_cnt == 2'd3)
        word_data <= {byte_data, acc};
      else
        acc[{byte_cnt, 3'b000} +: 8] <= byte_data;
    end
  end

endmodule

/* stepper_axis.sv */
`timescale 1ns/1ps

module stepper_axis import stepper_pkg::*; #(
  parameter int MOVE_DEPTH = 4,
  parameter int STEP_DIV   = 8,
  parameter int AXIS_ID    = 0
) (
  input  logic                    word_received,
  input  logic                    rst_n,
  input  logic                    move_push,
  input  logic [step_count_w-1:0] move_steps,
  output logic                    credit_return,
  output logic [7:0]              queue_level,
  input  logic [7:0]              pwm_duty_a,
  input  logic [7:0]              pwm_duty_b,
  output logic                    phase_a1,
  output logic                    phase_a2,
  output logic                    phase_b1,
  output logic                    phase_b2,
  output logic                    pwm_a,
  output logic                    pwm_b,
  output logic                    done_req,
  input  logic                    done_grant,
  output word_t                   done_data
);

  localparam int PW = (MOVE_DEPTH > 1) ? $clog2(MOVE_DEPTH) : 1;
  localparam int CW = $clog2(MOVE_DEPTH + 1);
  localparam int DW = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_run  = 2'd1;
  localparam logic [1:0] st_done = 2'd2; // Waiting for the done grant

  logic [step_count_w-1:0] mem [MOVE_DEPTH];
  logic [PW-1:0]           wr_ptr;
  logic [PW-1:0]           rd_ptr;
  logic [CW-1:0]           count;

  logic [1:0]              state;
  logic [DW-1:0]           div_cnt;
  logic [step_count_w-1:0] steps_left;
  logic [15:0]             move_tag;   // Low bits of the running move for the report
  logic [1:0]              phase;      // 0 A+, 1 B+, 2 A-, 3 B-
  logic                    energized;
  logic [7:0]              pwm_cnt;

  logic push;
  logic pop;
  logic tick;

  assign push = move_push && (count != CW'(MOVE_DEPTH));
  assign pop  = (state == st_idle) && (count != '0);
  assign tick = (div_cnt == DW'(STEP_DIV - 1));

  assign queue_level = 8'(count);
  assign done_data   = {reply_done_tag, 8'(AXIS_ID), move_tag};

  // Wave drive, one coil direction at a time
  assign phase_a1 = energized && (phase == 2'd0);
  assign phase_b1 = energized && (phase == 2'd1);
  assign phase_a2 = energized && (phase == 2'd2);
  assign phase_b2 = energized && (phase == 2'd3);

  always_ff @(posedge word_received) begin
    if (push)
      mem[wr_ptr] <= move_steps;
  end

  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      state         <= st_idle;
      div_cnt       <= '0;
      steps_left    <= '0;
      move_tag      <= 16'd0;
      phase         <= 2'd3;     // First step lands on A+
      energized     <= 1'b0;
      pwm_cnt       <= 8'd0;
      pwm_a         <= 1'b0;
      pwm_b         <= 1'b0;
      credit_return <= 1'b0;
      done_req      <= 1'b0;
    end else begin
      pwm_cnt       <= pwm_cnt + 8'd1;
      pwm_a         <= (state == st_run) && (pwm_cnt < pwm_duty_a);
      pwm_b         <= (state == st_run) && (pwm_cnt < pwm_duty_b);
      credit_return <= pop;
      count         <= count + CW'(push) - CW'(pop);

      if (push)
        wr_ptr <= (wr_ptr == PW'(MOVE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

      case (state)
        st_idle: if (pop) begin
          rd_ptr     <= (rd_ptr == PW'(MOVE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
          steps_left <= mem[rd_ptr];
          move_tag   <= mem[rd_ptr][15:0];
          div_cnt    <= '0;
          if (mem[rd_ptr] == '0) begin
            state    <= st_done; // Nothing to step
            done_req <= 1'b1;
          end else begin
            state <= st_run;
          end
        end
        st_run: begin
          div_cnt <= tick ? '0 : div_cnt + 1'b1;
          if (tick) begin
            energized  <= 1'b1;
            phase      <= phase + 2'd1;
            steps_left <= steps_left - step_count_w'(1);
            if (steps_left == step_count_w'(1)) begin
              state    <= st_done;
              done_req <= 1'b1;
            end
          end
        end
        st_done: if (done_grant) begin
          done_req <= 1'b0;
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* stepper_pkg.sv */
package stepper_pkg;

  typedef logic [31:0] word_t;   // One SPI word
  typedef logic [7:0]  opcode_t; // Top byte of a command word

  localparam opcode_t op_move0  = 8'h01; // Queue a move on axis 0
  localparam opcode_t op_move1  = 8'h02; // Queue a move on axis 1
  localparam opcode_t op_pwm    = 8'h03; // Coil PWM duties
  localparam opcode_t op_status = 8'h04; // Queue occupancy request

  localparam int step_count_w = 24;

  // Top bytes of the words the host reads back
  localparam logic [7:0] reply_done_tag   = 8'hD0;
  localparam logic [7:0] reply_status_tag = 8'h5A;

  // One received word, seen either as a move or as a configuration.
  // The opcode sits on the same bits in both views.
  typedef union packed {
    struct packed {
      opcode_t                 opcode;
      logic [step_count_w-1:0] steps;
    } move;
    struct packed {
      opcode_t    opcode;
      logic [7:0] duty_a;
      logic [7:0] duty_b;
      logic [7:0] rsvd;   // Ignored
    } cfg;
  } command_word_u;

endpackage

/* stepper_top.sv */
`timescale 1ns/1ps

module stepper_top import stepper_pkg::*; #(
  parameter int MOVE_DEPTH = 4,
  parameter int STEP_DIV   = 8
) (
  input  logic word_received,
  input  logic rst_n,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic axis0_phase_a1,
  output logic axis0_phase_a2,
  output logic axis0_phase_b1,
  output logic axis0_phase_b2,
  output logic axis0_pwm_a,
  output logic axis0_pwm_b,
  output logic axis1_phase_a1,
  output logic axis1_phase_a2,
  output logic axis1_phase_b1,
  output logic axis1_phase_b2,
  output logic axis1_pwm_a,
  output logic axis1_pwm_b
);

  logic [7:0] tx_byte;
  logic       byte_valid;
  logic [7:0] byte_data;
  logic       word_valid;
  word_t      word_data;
  word_t      reply_word;

  logic                    move_push0;
  logic                    move_push1;
  logic [step_count_w-1:0] move_steps;
  logic                    credit_return0;
  logic                    credit_return1;
  logic [7:0]              queue_level0;
  logic [7:0]              queue_level1;
  logic [7:0]              pwm_duty_a;
  logic [7:0]              pwm_duty_b;

  logic [2:0] req;   // 0 decoder, 1 axis 0, 2 axis 1
  logic [2:0] grant;
  word_t      req_data0;
  word_t      req_data1;
  word_t      req_data2;

  spi_slave i_spi_slave (
    .word_received (word_received),
    .rst_n         (rst_n),
    .sck           (sck),
    .ssel          (ssel),
    .mosi          (mosi),
    .miso          (miso),
    .tx_byte       (tx_byte),
    .byte_valid    (byte_valid),
    .byte_data     (byte_data)
  );

  spi_word_packer i_spi_word_packer (
    .word_received (word_received),
    .rst_n         (rst_n),
    .ssel          (ssel),
    .byte_valid    (byte_valid),
    .byte_data     (byte_data),
    .tx_byte       (tx_byte),
    .reply_word    (reply_word),
    .word_valid    (word_valid),
    .word_data     (word_data)
  );

  command_decoder #(
    .MOVE_DEPTH (MOVE_DEPTH)
  ) i_command_decoder (
    .word_received  (word_received),
    .rst_n          (rst_n),
    .word_valid     (word_valid),
    .word_data      (word_data),
    .move_push0     (move_push0),
    .move_push1     (move_push1),
    .move_steps     (move_steps),
    .credit_return0 (credit_return0),
    .credit_return1 (credit_return1),
    .queue_level0   (queue_level0),
    .queue_level1   (queue_level1),
    .pwm_duty_a     (pwm_duty_a),
    .pwm_duty_b     (pwm_duty_b),
    .reply_req      (req[0]),
    .reply_grant    (grant[0]),
    .reply_data     (req_data0)
  );

  stepper_axis #(
    .MOVE_DEPTH (MOVE_DEPTH),
    .STEP_DIV   (STEP_DIV),
    .AXIS_ID    (0)
  ) i_axis0 (
    .word_received (word_received),
    .rst_n         (rst_n),
    .move_push     (move_push0),
    .move_steps    (move_steps),
    .credit_return (credit_return0),
    .queue_level   (queue_level0),
    .pwm_duty_a    (pwm_duty_a),
    .pwm_duty_b    (pwm_duty_b),
    .phase_a1      (axis0_phase_a1),
    .phase_a2      (axis0_phase_a2),
    .phase_b1      (axis0_phase_b1),
    .phase_b2      (axis0_phase_b2),
    .pwm_a         (axis0_pwm_a),
    .pwm_b         (axis0_pwm_b),
    .done_req      (req[1]),
    .done_grant    (grant[1]),
    .done_data     (req_data1)
  );

  stepper_axis #(
    .MOVE_DEPTH (MOVE_DEPTH),
    .STEP_DIV   (STEP_DIV),
    .AXIS_ID    (1)
  ) i_axis1 (
    .word_received (word_received),
    .rst_n         (rst_n),
    .move_push     (move_push1),
    .move_steps    (move_steps),
    .credit_return (credit_return1),
    .queue_level   (queue_level1),
    .pwm_duty_a    (pwm_duty_a),
    .pwm_duty_b    (pwm_duty_b),
    .phase_a1      (axis1_phase_a1),
    .phase_a2      (axis1_phase_a2),
    .phase_b1      (axis1_phase_b1),
    .phase_b2      (axis1_phase_b2),
    .pwm_a         (axis1_pwm_a),
    .pwm_b         (axis1_pwm_b),
    .done_req      (req[2]),
    .done_grant    (grant[2]),
    .done_data     (req_data2)
  );

  reply_arbiter i_reply_arbiter (
    .word_received (word_received),
    .rst_n         (rst_n),
    .req           (req),
    .req_data0     (req_data0),
    .req_data1     (req_data1),
    .req_data2     (req_data2),
    .grant         (grant),
    .reply_word    (reply_word)
  );

endmodule

/* tb_stepper_top.sv */
`timescale 1ns/1ps

module tb_stepper_top import stepper_pkg::*; ();

  localparam int MOVE_DEPTH = 4;
  localparam int STEP_DIV   = 8;

  localparam int half_sck    = 4;   // System clocks per SCK half-period
  localparam int echo_words  = 6;
  localparam int pwm_steps   = 120;
  localparam int pwm_periods = 3;
  localparam int long_steps  = 500; // Outlasts the whole credit test
  localparam int word_clks   = 1 + 64 * half_sck + half_sck + 12;
  localparam int n_words     = (echo_words + 1) + 1 + 2 + 5 + (MOVE_DEPTH + 4);
  localparam int timeout_ns  = 2 * (n_words * word_clks + long_steps * STEP_DIV) * 100;

  logic word_received;
  logic rst_n;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic axis0_phase_a1;
  logic axis0_phase_a2;
  logic axis0_phase_b1;
  logic axis0_phase_b2;
  logic axis0_pwm_a;
  logic axis0_pwm_b;
  logic axis1_phase_a1;
  logic axis1_phase_a2;
  logic axis1_phase_b1;
  logic axis1_phase_b2;
  logic axis1_pwm_a;
  logic axis1_pwm_b;

  logic [3:0] phv [2];            // {A+, B+, A-, B-} per axis
  int         steps [2] = '{0, 0};
  int         last_ph [2] = '{-1, -1};
  int         stamps0 [$];        // Clock of each axis 0 phase change
  int         cycle = 0;

  stepper_top #(
    .MOVE_DEPTH (MOVE_DEPTH),
    .STEP_DIV   (STEP_DIV)
  ) i_stepper_top (
    .word_received  (word_received),
    .rst_n          (rst_n),
    .sck            (sck),
    .ssel           (ssel),
    .mosi           (mosi),
    .miso           (miso),
    .axis0_phase_a1 (axis0_phase_a1),
    .axis0_phase_a2 (axis0_phase_a2),
    .axis0_phase_b1 (axis0_phase_b1),
    .axis0_phase_b2 (axis0_phase_b2),
    .axis0_pwm_a    (axis0_pwm_a),
    .axis0_pwm_b    (axis0_pwm_b),
    .axis1_phase_a1 (axis1_phase_a1),
    .axis1_phase_a2 (axis1_phase_a2),
    .axis1_phase_b1 (axis1_phase_b1),
    .axis1_phase_b2 (axis1_phase_b2),
    .axis1_pwm_a    (axis1_pwm_a),
    .axis1_pwm_b    (axis1_pwm_b)
  );

  assign phv[0] = {axis0_phase_a1, axis0_phase_b1, axis0_phase_a2, axis0_phase_b2};
  assign phv[1] = {axis1_phase_a1, axis1_phase_b1, axis1_phase_a2, axis1_phase_b2};

  initial begin
    word_received = 1'b0;
    forever #50 word_received = ~word_received;
  end

  function automatic word_t done_word(int axis, int n);
    return {reply_done_tag, 8'(axis), 16'(n)};
  endfunction

  function automatic int phase_of(logic [3:0] v);
    case (v)
      4'b0000: return -1; // Coils off
      4'b1000: return 0;
      4'b0100: return 1;
      4'b0010: return 2;
      4'b0001: return 3;
      default: return 9;  // More than one coil driven
    endcase
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  task automatic step(input int n);
    repeat (n) @(posedge word_received);
    #10;
  endtask

  // One 32-bit SPI mode 0 transfer, lowest byte first, MSB first in a byte
  task automatic spi_word(input word_t tx, output word_t rx);
    step(1);
    ssel = 1'b0;
    for (int b = 0; b < 4; b++) begin
      for (int i = 7; i >= 0; i--) begin
        mosi = tx[b * 8 + i];
        step(half_sck);
        sck = 1'b1;
        rx[b * 8 + i] = miso;
        step(half_sck);
        sck = 1'b0;
      end
    end
    step(half_sck);
    ssel = 1'b1;
    step(12); // Reply settles while deselected
  endtask

  task automatic wait_steps(input int axis, input int target);
    while (steps[axis] < target)
      @(negedge word_received);
  endtask

  task automatic check_quiet(input string name);
    expect_eq(name, 32'h0, {axis0_phase_a1, axis0_phase_a2, axis0_phase_b1, axis0_phase_b2,
                            axis0_pwm_a, axis0_pwm_b, axis1_phase_a1, axis1_phase_a2,
                            axis1_phase_b1, axis1_phase_b2, axis1_pwm_a, axis1_pwm_b, miso});
  endtask

  always @(posedge word_received) cycle <= cycle + 1;

  // Phase monitor for both axes
  always @(negedge word_received) begin
    int ph;
    for (int a = 0; a < 2; a++) begin
      ph = phase_of(phv[a]);
      if (ph != last_ph[a]) begin
        expect_eq($sformatf("phase order axis %0d", a), (last_ph[a] + 1) % 4, ph);
        steps[a] = steps[a] + 1;
        if (a == 0)
          stamps0.push_back(cycle);
        last_ph[a] = ph;
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("Watchdog expired, the tests did not finish within %0d ns", timeout_ns);
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout");
  end

  initial begin
    word_t      rd;
    word_t      prev;
    word_t      w;
    word_t      seen [$];
    logic [7:0] duty_a;
    logic [7:0] duty_b;
    int         n;
    int         n0;
    int         n1;
    int         base;
    int         base1;
    int         hi_a;
    int         hi_b;
    int         cnt;
    int         credits;
    int         queued;
    int         drops;
    bit         running;

    void'($urandom(32'hd4c25ae2));
    rst_n = 1'b0;
    sck   = 1'b0;
    ssel  = 1'b1;
    mosi  = 1'b0;

    repeat (2) begin
      @(negedge word_received);
      check_quiet("reset held");
    end
    step(1);
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge word_received);
      check_quiet("after reset");
    end

    // Echo of words that are no command
    prev = '0;
    for (int k = 0; k <= echo_words; k++) begin
      w = {8'($urandom_range(255, 5)), 24'($urandom)};
      spi_word(w, rd);
      if (k > 0)
        expect_eq("echo", prev, rd);
      prev = w;
    end

    // Step order, count and spacing on axis 0
    n     = $urandom_range(20, 1);
    base  = steps[0];
    base1 = steps[1];
    stamps0.delete();
    spi_word({op_move0, 24'(n)}, rd);
    wait_steps(0, base + n);
    step(2 * STEP_DIV); // Room for a stray extra step
    expect_eq("step count", n, steps[0] - base);
    for (int i = 1; i < stamps0.size(); i++)
      expect_eq("step spacing", STEP_DIV, stamps0[i] - stamps0[i - 1]);
    expect_eq("axis 1 still", base1, steps[1]);

    // PWM duty over whole periods of the free-running counter
    duty_a = 8'($urandom);
    duty_b = 8'($urandom);
    spi_word({op_pwm, duty_a, duty_b, 8'h00}, rd);
    base = steps[0];
    spi_word({op_move0, 24'(pwm_steps)}, rd);
    wait_steps(0, base + 1);
    hi_a = 0;
    hi_b = 0;
    repeat (pwm_periods * 256) begin
      @(negedge word_received);
      hi_a = hi_a + int'(axis0_pwm_a);
      hi_b = hi_b + int'(axis0_pwm_b);
    end
    expect_eq("pwm a duty", pwm_periods * duty_a, hi_a);
    expect_eq("pwm b duty", pwm_periods * duty_b, hi_b);
    wait_steps(0, base + pwm_steps);
    step(2 * STEP_DIV);

    // Done reports, axis 1 finishing well after axis 0
    n0    = $urandom_range(80, 60);
    n1    = n0 + $urandom_range(100, 80);
    base  = steps[0];
    base1 = steps[1];
    spi_word({op_move0, 24'(n0)}, rd);
    spi_word({op_move1, 24'(n1)}, rd);
    wait_steps(0, base + n0);
    step(8);
    spi_word(32'h0, rd);
    seen.push_back(rd);
    wait_steps(1, base1 + n1);
    step(8);
    spi_word(32'h0, rd);
    seen.push_back(rd);
    spi_word(32'h0, rd);
    seen.push_back(rd);
    for (int a = 0; a < 2; a++) begin
      cnt = 0;
      foreach (seen[r])
        if (seen[r] == done_word(a, (a == 0) ? n0 : n1))
          cnt++;
      expect_eq($sformatf("done report axis %0d", a), 1, cnt);
    end

    // Credit flow, expected state from the credit rules
    credits = MOVE_DEPTH;
    running = 1'b0;
    queued  = 0;
    drops   = 0;
    for (int m = 0; m < MOVE_DEPTH + 2; m++) begin
      if (credits > 0) begin
        credits--;
        if (!running) begin
          running = 1'b1;
          credits++; // Idle axis pops at once and hands the credit back
        end else begin
          queued++;
        end
      end else begin
        drops++;
      end
      spi_word({op_move0, 24'(long_steps)}, rd);
    end
    spi_word({op_status, 24'h0}, rd);
    spi_word(32'h0, rd);
    expect_eq("status", {reply_status_tag, 8'(drops), 8'h00, 8'(queued)}, rd);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
